// ==== source/csr_pkg.sv ====
// CSR package: addresses, widths, encodings and the legal mcause table
package csr_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    localparam int XLEN      = 32;
    localparam int COUNTER_W = 64;
    localparam int ECODE_W   = 5;
    localparam int RETIRE_W  = 2;

    ////////////////////////////////////////////////////////////
    // Machine mode addresses
    localparam logic [11:0] MSTATUS   = 12'h300;
    localparam logic [11:0] MISA      = 12'h301;
    localparam logic [11:0] MTVEC     = 12'h305;
    localparam logic [11:0] MSCRATCH  = 12'h340;
    localparam logic [11:0] MEPC      = 12'h341;
    localparam logic [11:0] MCAUSE    = 12'h342;
    localparam logic [11:0] MTVAL     = 12'h343;
    localparam logic [11:0] MVENDORID = 12'hF11;
    localparam logic [11:0] MARCHID   = 12'hF12;
    localparam logic [11:0] MIMPID    = 12'hF13;
    localparam logic [11:0] MHARTID   = 12'hF14;
    localparam logic [11:0] MCYCLE    = 12'hB00;
    localparam logic [11:0] MINSTRET  = 12'hB02;
    localparam logic [11:0] MCYCLEH   = 12'hB80;
    localparam logic [11:0] MINSTRETH = 12'hB82;

    // User read-only counter aliases
    localparam logic [11:0] CYCLE    = 12'hC00;
    localparam logic [11:0] TIME     = 12'hC01;
    localparam logic [11:0] INSTRET  = 12'hC02;
    localparam logic [11:0] CYCLEH   = 12'hC80;
    localparam logic [11:0] TIMEH    = 12'hC81;
    localparam logic [11:0] INSTRETH = 12'hC82;

    // Identity constants, MXL=1 with I and M
    localparam logic [XLEN-1:0] MISA_VALUE   = 32'h4000_1100;
    localparam logic [XLEN-1:0] MIMPID_VALUE = 32'h0000_0001;
    localparam logic [XLEN-1:0] HART_ID      = 32'h0000_0000;

    // mstatus field positions
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;

    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_t;

    typedef enum logic [ECODE_W-1:0] {
        EXC_INST_MISALIGNED  = 5'd0,
        EXC_ILLEGAL_INST     = 5'd2,
        EXC_BREAKPOINT       = 5'd3,
        EXC_LOAD_MISALIGNED  = 5'd4,
        EXC_STORE_MISALIGNED = 5'd6,
        EXC_ECALL_U          = 5'd8,
        EXC_ECALL_M          = 5'd11
    } exc_code_t;

    // Decoded register selector shared by all blocks
    typedef enum logic [4:0] {
        CSR_NONE, CSR_MSTATUS, CSR_MISA, CSR_MTVEC, CSR_MSCRATCH,
        CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MVENDORID, CSR_MARCHID,
        CSR_MIMPID, CSR_MHARTID, CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET,
        CSR_MINSTRETH, CSR_CYCLE, CSR_CYCLEH, CSR_TIME, CSR_TIMEH,
        CSR_INSTRET, CSR_INSTRETH
    } csr_id_t;

    // One bit per exception code, interrupts are never legal
    localparam logic [2**ECODE_W-1:0] MCAUSE_LEGAL =
        (32'd1 << EXC_INST_MISALIGNED) | (32'd1 << EXC_ILLEGAL_INST) |
        (32'd1 << EXC_BREAKPOINT) | (32'd1 << EXC_LOAD_MISALIGNED) |
        (32'd1 << EXC_STORE_MISALIGNED) | (32'd1 << EXC_ECALL_U) |
        (32'd1 << EXC_ECALL_M);

endpackage

// ==== source/csr_access.sv ====
// CSR access decoder: address decode, privilege check and read-modify-write value
`timescale 1ns/1ns

module csr_access
    import csr_pkg::*;
(
    input  logic [11:0]     csr_addr,
    input  csr_op_t         csr_op,
    input  logic [XLEN-1:0] rs1,
    input  logic            new_request,
    input  logic            commit,
    input  priv_t           current_privilege,
    input  logic [XLEN-1:0] rd_value,
    output logic            csr_exc,
    output csr_id_t         csr_id,
    output logic            wr_en,
    output logic [XLEN-1:0] wr_data
);

    logic invalid_addr;
    logic priv_fail;
    logic read_only;

    ////////////////////////////////////////////////////////////
    // Address decode
    always_comb begin
        case (csr_addr)
            MSTATUS:   csr_id = CSR_MSTATUS;
            MISA:      csr_id = CSR_MISA;
            MTVEC:     csr_id = CSR_MTVEC;
            MSCRATCH:  csr_id = CSR_MSCRATCH;
            MEPC:      csr_id = CSR_MEPC;
            MCAUSE:    csr_id = CSR_MCAUSE;
            MTVAL:     csr_id = CSR_MTVAL;
            MVENDORID: csr_id = CSR_MVENDORID;
            MARCHID:   csr_id = CSR_MARCHID;
            MIMPID:    csr_id = CSR_MIMPID;
            MHARTID:   csr_id = CSR_MHARTID;
            MCYCLE:    csr_id = CSR_MCYCLE;
            MCYCLEH:   csr_id = CSR_MCYCLEH;
            MINSTRET:  csr_id = CSR_MINSTRET;
            MINSTRETH: csr_id = CSR_MINSTRETH;
            CYCLE:     csr_id = CSR_CYCLE;
            CYCLEH:    csr_id = CSR_CYCLEH;
            TIME:      csr_id = CSR_TIME;
            TIMEH:     csr_id = CSR_TIMEH;
            INSTRET:   csr_id = CSR_INSTRET;
            INSTRETH:  csr_id = CSR_INSTRETH;
            default:   csr_id = CSR_NONE;
        endcase
    end

    assign invalid_addr = (csr_id == CSR_NONE);

    // Address bits 9:8 give the lowest privilege allowed
    assign priv_fail = (csr_addr[9:8] > current_privilege);
    assign csr_exc   = new_request & (invalid_addr | priv_fail);

    ////////////////////////////////////////////////////////////
    // Write value and strobe
    assign read_only = (csr_addr[11:10] == 2'b11);
    assign wr_en     = commit & ~read_only;

    always_comb begin
        case (csr_op)
            CSR_RW:  wr_data = rs1;
            CSR_RS:  wr_data = rd_value | rs1;
            CSR_RC:  wr_data = rd_value & ~rs1;
            default: wr_data = rs1;
        endcase
    end

endmodule

// ==== source/csr_trap_ctrl.sv ====
// Trap and privilege controller: privilege level, mstatus, mepc, mcause and mtval
`timescale 1ns/1ns

module csr_trap_ctrl
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  csr_id_t         csr_id,
    input  logic            wr_en,
    input  logic [XLEN-1:0] wr_data,
    input  logic            exc_valid,
    input  exc_code_t       exc_code,
    input  logic [XLEN-1:0] exc_tval,
    input  logic [XLEN-1:0] exc_pc,
    input  logic            mret,
    output priv_t           current_privilege,
    output logic [XLEN-1:0] mstatus,
    output logic [XLEN-1:0] mepc,
    output logic [XLEN-1:0] mcause,
    output logic [XLEN-1:0] mtval
);

    logic  mie;
    logic  mpie;
    priv_t mpp;
    priv_t privilege;

    logic  mstatus_wr;
    logic  mepc_wr;
    logic  mcause_wr;
    logic  mtval_wr;
    logic  mcause_legal;

    assign mstatus_wr = wr_en & (csr_id == CSR_MSTATUS);
    assign mepc_wr    = wr_en & (csr_id == CSR_MEPC);
    assign mcause_wr  = wr_en & (csr_id == CSR_MCAUSE);
    assign mtval_wr   = wr_en & (csr_id == CSR_MTVAL);

    ////////////////////////////////////////////////////////////
    // Privilege level
    always_ff @(posedge clk) begin
        if (rst)
            privilege <= PRIV_M;
        else if (exc_valid)
            privilege <= PRIV_M;
        else if (mret)
            privilege <= mpp;
    end

    assign current_privilege = privilege;

    ////////////////////////////////////////////////////////////
    // mstatus, CSR write first, then trap, then mret
    always_ff @(posedge clk) begin
        if (rst) begin
            mie  <= 1'b0;
            mpie <= 1'b0;
            mpp  <= PRIV_M;
        end else if (mstatus_wr) begin
            mie  <= wr_data[MSTATUS_MIE];
            mpie <= wr_data[MSTATUS_MPIE];
            // Only U and M exist, anything else falls back to U
            mpp  <= (wr_data[MSTATUS_MPP_LO +: 2] == PRIV_M) ? PRIV_M : PRIV_U;
        end else if (exc_valid) begin
            mpie <= mie;
            mie  <= 1'b0;
            mpp  <= privilege;
        end else if (mret) begin
            mie  <= mpie;
            mpie <= 1'b1;
            mpp  <= PRIV_U;
        end
    end

    always_comb begin
        mstatus = '0;
        mstatus[MSTATUS_MIE] = mie;
        mstatus[MSTATUS_MPIE] = mpie;
        mstatus[MSTATUS_MPP_LO +: 2] = mpp;
    end

    ////////////////////////////////////////////////////////////
    // Trap registers, a trap wins over a write
    assign mcause_legal = ~wr_data[XLEN-1] & MCAUSE_LEGAL[wr_data[ECODE_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else if (exc_valid) begin
            mepc   <= {exc_pc[XLEN-1:2], 2'b00};
            mcause <= {{(XLEN-ECODE_W){1'b0}}, exc_code};
            mtval  <= exc_tval;
        end else begin
            if (mepc_wr)
                mepc <= {wr_data[XLEN-1:2], 2'b00};
            // Illegal codes leave mcause untouched
            if (mcause_wr && mcause_legal)
                mcause <= {wr_data[XLEN-1], {(XLEN-1-ECODE_W){1'b0}},
                           wr_data[ECODE_W-1:0]};
            if (mtval_wr)
                mtval <= wr_data;
        end
    end

endmodule

// ==== source/csr_counters.sv ====
// Counter block: 64-bit cycle and retired instruction counters
`timescale 1ns/1ns

module csr_counters
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  csr_id_t              csr_id,
    input  logic                 wr_en,
    input  logic [XLEN-1:0]      wr_data,
    input  logic [RETIRE_W-1:0]  retire_inc,
    output logic [COUNTER_W-1:0] mcycle,
    output logic [COUNTER_W-1:0] minstret
);

    logic [COUNTER_W-1:0] mcycle_next;
    logic [COUNTER_W-1:0] minstret_next;

    // Add first, then let a half write override the sum
    function automatic logic [COUNTER_W-1:0] step_count(
        input logic [COUNTER_W-1:0] count,
        input logic [COUNTER_W-1:0] inc,
        input logic                 wr_lo,
        input logic                 wr_hi,
        input logic [XLEN-1:0]      data
    );
        logic [COUNTER_W-1:0] sum;
        sum = count + inc;
        if (wr_lo)
            sum[XLEN-1:0] = data;
        if (wr_hi)
            sum[COUNTER_W-1:XLEN] = data[COUNTER_W-XLEN-1:0];
        return sum;
    endfunction

    assign mcycle_next = step_count(mcycle, COUNTER_W'(1),
                                    wr_en && (csr_id == CSR_MCYCLE),
                                    wr_en && (csr_id == CSR_MCYCLEH), wr_data);

    assign minstret_next = step_count(minstret, COUNTER_W'(retire_inc),
                                      wr_en && (csr_id == CSR_MINSTRET),
                                      wr_en && (csr_id == CSR_MINSTRETH), wr_data);

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle   <= mcycle_next;
            minstret <= minstret_next;
        end
    end

endmodule

// ==== source/csr_regs.sv ====
// Register block: mtvec, mscratch, identity constants and the registered read mux
`timescale 1ns/1ns

module csr_regs
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  csr_id_t              csr_id,
    input  logic                 wr_en,
    input  logic [XLEN-1:0]      wr_data,
    input  logic                 read_regs,
    input  logic [XLEN-1:0]      mstatus,
    input  logic [XLEN-1:0]      mepc,
    input  logic [XLEN-1:0]      mcause,
    input  logic [XLEN-1:0]      mtval,
    input  logic [COUNTER_W-1:0] mcycle,
    input  logic [COUNTER_W-1:0] minstret,
    output logic [XLEN-1:0]      trap_pc,
    output logic [XLEN-1:0]      rd_value
);

    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] selected;

    ////////////////////////////////////////////////////////////
    // Writable machine registers
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= '0;
            mscratch <= '0;
        end else if (wr_en) begin
            // Direct mode only, so the mode bits stay zero
            if (csr_id == CSR_MTVEC)
                mtvec <= {wr_data[XLEN-1:2], 2'b00};
            if (csr_id == CSR_MSCRATCH)
                mscratch <= wr_data;
        end
    end

    assign trap_pc = mtvec;

    ////////////////////////////////////////////////////////////
    // Read mux
    always_comb begin
        case (csr_id)
            CSR_MSTATUS:   selected = mstatus;
            CSR_MISA:      selected = MISA_VALUE;
            CSR_MTVEC:     selected = mtvec;
            CSR_MSCRATCH:  selected = mscratch;
            CSR_MEPC:      selected = mepc;
            CSR_MCAUSE:    selected = mcause;
            CSR_MTVAL:     selected = mtval;
            CSR_MVENDORID: selected = '0;
            CSR_MARCHID:   selected = '0;
            CSR_MIMPID:    selected = MIMPID_VALUE;
            CSR_MHARTID:   selected = HART_ID;
            // time has no separate source and follows mcycle
            CSR_MCYCLE, CSR_CYCLE, CSR_TIME:
                selected = mcycle[XLEN-1:0];
            CSR_MCYCLEH, CSR_CYCLEH, CSR_TIMEH:
                selected = mcycle[COUNTER_W-1:XLEN];
            CSR_MINSTRET, CSR_INSTRET:
                selected = minstret[XLEN-1:0];
            CSR_MINSTRETH, CSR_INSTRETH:
                selected = minstret[COUNTER_W-1:XLEN];
            default:       selected = '0;
        endcase
    end

    // Held until the next read so set and clear see a stable old value
    always_ff @(posedge clk) begin
        if (rst)
            rd_value <= '0;
        else if (read_regs)
            rd_value <= selected;
    end

endmodule

// ==== source/csr_unit.sv ====
// Machine-mode CSR unit top level connecting decoder, trap control, counters and registers
`timescale 1ns/1ns

module csr_unit
    import csr_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [11:0]         csr_addr,
    input  csr_op_t             csr_op,
    input  logic [XLEN-1:0]     rs1,
    input  logic                new_request,
    input  logic                read_regs,
    input  logic                commit,
    input  logic                exc_valid,
    input  exc_code_t           exc_code,
    input  logic [XLEN-1:0]     exc_tval,
    input  logic [XLEN-1:0]     exc_pc,
    input  logic                mret,
    input  logic [RETIRE_W-1:0] retire_inc,
    output logic                csr_exc,
    output priv_t               current_privilege,
    output logic [XLEN-1:0]     wb_csr,
    output logic [XLEN-1:0]     trap_pc,
    output logic [XLEN-1:0]     csr_mepc
);

    csr_id_t              csr_id;
    logic                 wr_en;
    logic [XLEN-1:0]      wr_data;
    logic [XLEN-1:0]      rd_value;
    logic [XLEN-1:0]      mstatus;
    logic [XLEN-1:0]      mcause;
    logic [XLEN-1:0]      mtval;
    logic [COUNTER_W-1:0] mcycle;
    logic [COUNTER_W-1:0] minstret;

    csr_access u_access (
        .csr_addr          (csr_addr),
        .csr_op            (csr_op),
        .rs1               (rs1),
        .new_request       (new_request),
        .commit            (commit),
        .current_privilege (current_privilege),
        .rd_value          (rd_value),
        .csr_exc           (csr_exc),
        .csr_id            (csr_id),
        .wr_en             (wr_en),
        .wr_data           (wr_data)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk               (clk),
        .rst               (rst),
        .csr_id            (csr_id),
        .wr_en             (wr_en),
        .wr_data           (wr_data),
        .exc_valid         (exc_valid),
        .exc_code          (exc_code),
        .exc_tval          (exc_tval),
        .exc_pc            (exc_pc),
        .mret              (mret),
        .current_privilege (current_privilege),
        .mstatus           (mstatus),
        .mepc              (csr_mepc),
        .mcause            (mcause),
        .mtval             (mtval)
    );

    csr_counters u_counters (
        .clk        (clk),
        .rst        (rst),
        .csr_id     (csr_id),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .retire_inc (retire_inc),
        .mcycle     (mcycle),
        .minstret   (minstret)
    );

    csr_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .csr_id    (csr_id),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .read_regs (read_regs),
        .mstatus   (mstatus),
        .mepc      (csr_mepc),
        .mcause    (mcause),
        .mtval     (mtval),
        .mcycle    (mcycle),
        .minstret  (minstret),
        .trap_pc   (trap_pc),
        .rd_value  (rd_value)
    );

    assign wb_csr = rd_value;

endmodule

// ==== testbench/tb_clkgen.sv ====
// Clock and reset generator for the CSR testbench
`timescale 1ns/1ns

module tb_clkgen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 16 cycles, released just after an edge
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// ==== testbench/csr_sva.sv ====
// Concurrent assertions on the CSR unit outputs, bound into csr_unit
`timescale 1ns/1ns

module csr_sva
    import csr_pkg::*;
(
    input logic            clk,
    input logic            rst,
    input logic            new_request,
    input logic            csr_exc,
    input logic            exc_valid,
    input priv_t           current_privilege,
    input logic [XLEN-1:0] trap_pc,
    input logic [XLEN-1:0] csr_mepc
);

    // Access fault only alongside a request
    exc_needs_request: assert property (@(posedge clk) disable iff (rst)
        csr_exc |-> new_request)
        else $error("csr_exc high without new_request");

    // Trap always lands in machine mode
    trap_enters_m: assert property (@(posedge clk) disable iff (rst)
        exc_valid |=> current_privilege == PRIV_M)
        else $error("privilege not machine after a trap");

    trap_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        trap_pc[1:0] == 2'b00)
        else $error("trap_pc low bits not zero");

    mepc_aligned: assert property (@(posedge clk) disable iff (rst)
        csr_mepc[1:0] == 2'b00)
        else $error("csr_mepc low bits not zero");

endmodule

bind csr_unit csr_sva u_sva (
    .clk               (clk),
    .rst               (rst),
    .new_request       (new_request),
    .csr_exc           (csr_exc),
    .exc_valid         (exc_valid),
    .current_privilege (current_privilege),
    .trap_pc           (trap_pc),
    .csr_mepc          (csr_mepc)
);

// ==== testbench/tb_csr.sv ====
// Random testbench for the CSR unit with a cycle-accurate reference model
`timescale 1ns/1ns

module tb_csr
    import csr_pkg::*;
();

    localparam int NUM_TRANS   = 3000;
    localparam int CYCLE_LIMIT = 2 * NUM_TRANS * 4;

    localparam logic [11:0] ADDRS [21] = '{
        MSTATUS, MISA, MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL,
        MVENDORID, MARCHID, MIMPID, MHARTID, MCYCLE, MCYCLEH, MINSTRET,
        MINSTRETH, CYCLE, CYCLEH, TIME, TIMEH, INSTRET, INSTRETH
    };
    localparam csr_op_t   OPS [3]   = '{CSR_RW, CSR_RS, CSR_RC};
    localparam exc_code_t CODES [7] = '{
        EXC_INST_MISALIGNED, EXC_ILLEGAL_INST, EXC_BREAKPOINT, EXC_LOAD_MISALIGNED,
        EXC_STORE_MISALIGNED, EXC_ECALL_U, EXC_ECALL_M
    };

    logic                clk;
    logic                rst;
    logic [11:0]         csr_addr;
    csr_op_t             csr_op;
    logic [XLEN-1:0]     rs1;
    logic                new_request;
    logic                read_regs;
    logic                commit;
    logic                exc_valid;
    exc_code_t           exc_code;
    logic [XLEN-1:0]     exc_tval;
    logic [XLEN-1:0]     exc_pc;
    logic                mret;
    logic [RETIRE_W-1:0] retire_inc;
    logic                csr_exc;
    priv_t               current_privilege;
    logic [XLEN-1:0]     wb_csr;
    logic [XLEN-1:0]     trap_pc;
    logic [XLEN-1:0]     csr_mepc;

    integer seed;
    int     cycle_count = 0;
    int     word_errs;
    int     priv_errs;
    int     bit_errs;

    // Reference model state
    priv_t                m_priv;
    priv_t                m_mpp;
    logic                 m_mie;
    logic                 m_mpie;
    logic [XLEN-1:0]      m_mtvec;
    logic [XLEN-1:0]      m_mscratch;
    logic [XLEN-1:0]      m_mepc;
    logic [XLEN-1:0]      m_mcause;
    logic [XLEN-1:0]      m_mtval;
    logic [XLEN-1:0]      m_wb;
    logic [COUNTER_W-1:0] m_mcycle;
    logic [COUNTER_W-1:0] m_minstret;

    tb_clkgen u_clkgen (.clk(clk), .rst(rst));

    csr_unit uut (
        .clk               (clk),
        .rst               (rst),
        .csr_addr          (csr_addr),
        .csr_op            (csr_op),
        .rs1               (rs1),
        .new_request       (new_request),
        .read_regs         (read_regs),
        .commit            (commit),
        .exc_valid         (exc_valid),
        .exc_code          (exc_code),
        .exc_tval          (exc_tval),
        .exc_pc            (exc_pc),
        .mret              (mret),
        .retire_inc        (retire_inc),
        .csr_exc           (csr_exc),
        .current_privilege (current_privilege),
        .wb_csr            (wb_csr),
        .trap_pc           (trap_pc),
        .csr_mepc          (csr_mepc)
    );

    //////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            word_errs++;
            $display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_priv(input string name, input priv_t exp, input priv_t act);
        if (act !== exp) begin
            priv_errs++;
            $display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            bit_errs++;
            $display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Model helpers
    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic logic is_decoded(input logic [11:0] addr);
        for (int i = 0; i < 21; i++)
            if (ADDRS[i] == addr)
                return 1'b1;
        return 1'b0;
    endfunction

    // Exception codes only, interrupt bit never accepted
    function automatic logic cause_is_legal(input logic [XLEN-1:0] value);
        if (value[XLEN-1])
            return 1'b0;
        case (value[4:0])
            5'd0, 5'd2, 5'd3, 5'd4, 5'd6, 5'd8, 5'd11: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model_read(input logic [11:0] addr);
        logic [XLEN-1:0] status;
        status = '0;
        status[3] = m_mie;
        status[7] = m_mpie;
        status[12:11] = m_mpp;
        case (addr)
            MSTATUS:                return status;
            MISA:                   return MISA_VALUE;
            MTVEC:                  return m_mtvec;
            MSCRATCH:               return m_mscratch;
            MEPC:                   return m_mepc;
            MCAUSE:                 return m_mcause;
            MTVAL:                  return m_mtval;
            MIMPID:                 return MIMPID_VALUE;
            MHARTID:                return HART_ID;
            MCYCLE, CYCLE, TIME:    return m_mcycle[31:0];
            MCYCLEH, CYCLEH, TIMEH: return m_mcycle[63:32];
            MINSTRET, INSTRET:      return m_minstret[31:0];
            MINSTRETH, INSTRETH:    return m_minstret[63:32];
            default:                return '0;
        endcase
    endfunction

    // State update at one rising edge from the inputs held over the cycle
    task automatic update_model();
        logic [XLEN-1:0]      wd;
        logic                 wr;
        logic [COUNTER_W-1:0] cyc;
        logic [COUNTER_W-1:0] ret;
        priv_t                old_priv;
        old_priv = m_priv;
        wr = commit && is_decoded(csr_addr) && (csr_addr[11:10] != 2'b11);
        case (csr_op)
            CSR_RS:  wd = m_wb | rs1;
            CSR_RC:  wd = m_wb & ~rs1;
            default: wd = rs1;
        endcase
        // Read first so it sees the old state
        if (read_regs)
            m_wb = model_read(csr_addr);

        cyc = m_mcycle + 64'd1;
        ret = m_minstret + COUNTER_W'(retire_inc);
        if (wr && csr_addr == MCYCLE)
            cyc[31:0] = wd;
        if (wr && csr_addr == MCYCLEH)
            cyc[63:32] = wd;
        if (wr && csr_addr == MINSTRET)
            ret[31:0] = wd;
        if (wr && csr_addr == MINSTRETH)
            ret[63:32] = wd;
        m_mcycle = cyc;
        m_minstret = ret;

        if (exc_valid)
            m_priv = PRIV_M;
        else if (mret)
            m_priv = m_mpp;

        if (wr && csr_addr == MSTATUS) begin
            m_mie = wd[3];
            m_mpie = wd[7];
            m_mpp = (wd[12:11] == 2'b11) ? PRIV_M : PRIV_U;
        end else if (exc_valid) begin
            m_mpie = m_mie;
            m_mie = 1'b0;
            m_mpp = old_priv;
        end else if (mret) begin
            m_mie = m_mpie;
            m_mpie = 1'b1;
            m_mpp = PRIV_U;
        end

        if (exc_valid) begin
            m_mepc = {exc_pc[XLEN-1:2], 2'b00};
            m_mcause = {{(XLEN-ECODE_W){1'b0}}, exc_code};
            m_mtval = exc_tval;
        end
        if (wr) begin
            case (csr_addr)
                MTVEC:    m_mtvec = {wd[XLEN-1:2], 2'b00};
                MSCRATCH: m_mscratch = wd;
                MEPC:     if (!exc_valid) m_mepc = {wd[XLEN-1:2], 2'b00};
                MTVAL:    if (!exc_valid) m_mtval = wd;
                MCAUSE:   if (!exc_valid && cause_is_legal(wd))
                              m_mcause = {{(XLEN-ECODE_W){1'b0}}, wd[ECODE_W-1:0]};
                default:  ;
            endcase
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Stimulus
    task automatic next_cycle();
        @(posedge clk);
        update_model();
        #1;
        check_word("wb_csr", m_wb, wb_csr);
        check_word("trap_pc", m_mtvec, trap_pc);
        check_word("csr_mepc", m_mepc, csr_mepc);
        check_priv("current_privilege", m_priv, current_privilege);
        new_request = 1'b0;
        read_regs = 1'b0;
        commit = 1'b0;
        exc_valid = 1'b0;
        mret = 1'b0;
        retire_inc = RETIRE_W'(next_random());
    endtask

    task automatic drive_trap();
        exc_valid = 1'b1;
        exc_code = CODES[int'(next_random() % 7)];
        exc_tval = next_random();
        exc_pc = next_random();
    endtask

    task automatic run_access();
        logic [11:0]     addr;
        logic [XLEN-1:0] data;
        logic            exp_exc;
        if (next_random() % 8 == 0)
            addr = 12'(next_random());
        else
            addr = ADDRS[int'(next_random() % 21)];
        data = next_random();
        // Keep enough mcause writes legal
        if (addr == MCAUSE)
            data = data & 32'h8000_001F;
        csr_addr = addr;
        csr_op = OPS[int'(next_random() % 3)];
        rs1 = data;
        new_request = 1'b1;
        exp_exc = !is_decoded(addr) || (addr[9:8] > m_priv);
        @(negedge clk);
        check_bit("csr_exc", exp_exc, csr_exc);
        next_cycle();
        if (!exp_exc) begin
            read_regs = 1'b1;
            next_cycle();
            commit = 1'b1;
            // Occasional trap on the commit cycle
            if (next_random() % 8 == 0)
                drive_trap();
            next_cycle();
        end
    endtask

    always @(posedge clk) begin
        if (!rst)
            cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("Timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int pick;
        seed = 57;
        word_errs = 0;
        priv_errs = 0;
        bit_errs = 0;
        csr_addr = '0;
        csr_op = CSR_RW;
        rs1 = '0;
        new_request = 1'b0;
        read_regs = 1'b0;
        commit = 1'b0;
        exc_valid = 1'b0;
        exc_code = EXC_INST_MISALIGNED;
        exc_tval = '0;
        exc_pc = '0;
        mret = 1'b0;
        retire_inc = '0;
        // Reset values
        m_priv = PRIV_M;
        m_mpp = PRIV_M;
        m_mie = 1'b0;
        m_mpie = 1'b0;
        m_mtvec = '0;
        m_mscratch = '0;
        m_mepc = '0;
        m_mcause = '0;
        m_mtval = '0;
        m_wb = '0;
        m_mcycle = '0;
        m_minstret = '0;

        wait (rst == 1'b1);
        wait (rst == 1'b0);
        for (int n = 0; n < NUM_TRANS; n++) begin
            pick = int'(next_random() % 16);
            if (pick < 10) begin
                run_access();
            end else if (pick < 12) begin
                drive_trap();
                next_cycle();
            end else if (pick < 14) begin
                mret = 1'b1;
                next_cycle();
            end else begin
                repeat (int'(next_random() % 3) + 1) next_cycle();
            end
        end
        repeat (2) next_cycle();

        $display("Errors: word %0d, privilege %0d, csr_exc %0d",
                 word_errs, priv_errs, bit_errs);
        if (word_errs + priv_errs + bit_errs == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== sources.f ====
source/csr_pkg.sv
source/csr_access.sv
source/csr_trap_ctrl.sv
source/csr_counters.sv
source/csr_regs.sv
source/csr_unit.sv
testbench/tb_clkgen.sv
testbench/csr_sva.sv
testbench/tb_csr.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_csr -Mdir obj_dir -f sources.f
	./obj_dir/Vtb_csr > sim.log 2>&1 || true
	cat sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
